/* project.f */
design/fetch_pkg.sv
design/fetch_bus_ctrl.sv
design/pc_gen.sv
design/fetch_output.sv
design/fetch_top.sv
test/tb_clock.sv
test/fetch_mem_model.sv
test/fetch_assertions.sv
test/fetch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam addr_t RESET_PC     = 64'h0000_0000_8000_0000;
    localparam int    RESET_CYCLES = 8;
    localparam int    CLK_NS       = 20;
    // deliveries over all tests, 6 + 20 + 8 + 7 + 12 + 7
    localparam int    DELIVERIES   = 60;
    // worst case cycles per delivery, a dropped stale fetch included
    localparam int    MAX_LAT      = 32;
    localparam int    TIMEOUT_NS   = (RESET_CYCLES + DELIVERIES * MAX_LAT) * CLK_NS;

    logic  clk;
    logic  rst_n_i;
    logic  jal_i, branch_i, jalr_i, trap_i, stall_i;
    addr_t alu_res_i, ex_pc_i, imm_i, rs1_data_i, mtvec_i;
    logic  req_valid_o, req_ready_i, resp_valid_i, resp_ready_o;
    addr_t req_addr_o;
    data_t resp_data_i;
    logic  inst_valid_o;
    inst_t inst_o;
    addr_t pc_o;

    int addr_errors = 0;
    int inst_errors = 0;

    // pc expected at the start of the next test
    addr_t resume_pc;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk_o(clk));

    fetch_top #(.RESET_PC(RESET_PC)) UUT (.*);

    fetch_mem_model u_mem (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_o),
        .req_addr_i   (req_addr_o),
        .req_ready_o  (req_ready_i),
        .resp_valid_o (resp_valid_i),
        .resp_data_o  (resp_data_i),
        .resp_ready_i (resp_ready_o)
    );

    // lower half is the aligned address xor 0x13, upper half adds 4
    function automatic inst_t expected_inst(input addr_t pc);
        inst_t lo;
        lo = {pc[31:3], 3'b000} ^ 32'h13;
        return pc[2] ? lo + 32'd4 : lo;
    endfunction

    task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            addr_errors++;
            $display("error %s pc: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_inst(input string name, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            inst_errors++;
            $display("error %s inst: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic next_delivery(output addr_t pc, output inst_t inst);
        do begin
            @(posedge clk);
        end while (!inst_valid_o);
        pc   = pc_o;
        inst = inst_o;
    endtask

    task automatic check_run(input string name, input addr_t start, input int count);
        addr_t pc;
        inst_t inst;
        addr_t exp_pc;
        for (int k = 0; k < count; k++) begin
            next_delivery(pc, inst);
            exp_pc = start + addr_t'(4 * k);
            compare_addr(name, exp_pc, pc);
            compare_inst(name, expected_inst(exp_pc), inst);
        end
    endtask

    // wait for a delivery and check it, then raise the given strobes for one cycle
    task automatic strobe_after_delivery(input string name, input addr_t exp_pc,
                                         input logic jal, input logic branch,
                                         input logic jalr, input logic trap);
        addr_t pc;
        inst_t inst;
        next_delivery(pc, inst);
        compare_addr(name, exp_pc, pc);
        compare_inst(name, expected_inst(exp_pc), inst);
        jal_i    <= jal;
        branch_i <= branch;
        jalr_i   <= jalr;
        trap_i   <= trap;
        @(posedge clk);
        jal_i    <= 1'b0;
        branch_i <= 1'b0;
        jalr_i   <= 1'b0;
        trap_i   <= 1'b0;
    endtask

    task automatic test_jal(input addr_t from, output addr_t next_pc);
        addr_t ex_pc;
        addr_t imm;
        addr_t target;
        ex_pc  = 64'h0000_0000_8000_0300;
        imm    = 64'h0000_0000_0000_0104;
        target = ex_pc + imm;
        ex_pc_i <= ex_pc;
        imm_i   <= imm;
        mtvec_i <= 64'h0000_0000_8000_0100;
        strobe_after_delivery("jal", from, 1'b1, 1'b0, 1'b0, 1'b0);
        check_run("jal", target, 3);
        strobe_after_delivery("jal_over_trap", target + 64'd12, 1'b1, 1'b0, 1'b0, 1'b1);
        check_run("jal_over_trap", target, 3);
        next_pc = target + 64'd12;
    endtask

    task automatic test_branch(input addr_t from, output addr_t next_pc);
        addr_t ex_pc;
        addr_t imm;
        addr_t target;
        ex_pc  = 64'h0000_0000_8000_0800;
        imm    = 64'h0000_0000_0000_0024;
        target = ex_pc + imm;
        ex_pc_i   <= ex_pc;
        imm_i     <= imm;
        alu_res_i <= '0;
        strobe_after_delivery("branch_taken", from, 1'b0, 1'b1, 1'b0, 1'b0);
        check_run("branch_taken", target, 3);
        // nonzero compare result keeps the sequence going
        alu_res_i <= 64'd5;
        strobe_after_delivery("branch_not_taken", target + 64'd12, 1'b0, 1'b1, 1'b0, 1'b0);
        check_run("branch_not_taken", target + 64'd16, 2);
        next_pc = target + 64'd24;
    endtask

    task automatic test_jalr_trap(input addr_t from, output addr_t next_pc);
        addr_t rs1;
        addr_t imm;
        addr_t mtvec;
        addr_t target;
        rs1    = 64'h0000_0000_8000_2005;
        imm    = 64'h0000_0000_0000_0010;
        mtvec  = 64'h0000_0000_8000_0100;
        target = (rs1 + imm) & ~64'd1;
        rs1_data_i <= rs1;
        imm_i      <= imm;
        mtvec_i    <= mtvec;
        strobe_after_delivery("jalr", from, 1'b0, 1'b0, 1'b1, 1'b0);
        check_run("jalr", target, 3);
        from   = target + 64'd12;
        rs1    = 64'h0000_0000_8000_3001;
        target = (rs1 + imm) & ~64'd1;
        rs1_data_i <= rs1;
        strobe_after_delivery("jalr_over_trap", from, 1'b0, 1'b0, 1'b1, 1'b1);
        check_run("jalr_over_trap", target, 3);
        strobe_after_delivery("trap", target + 64'd12, 1'b0, 1'b0, 1'b0, 1'b1);
        check_run("trap", mtvec, 3);
        next_pc = mtvec + 64'd12;
    endtask

    task automatic test_stall(input addr_t from);
        addr_t pc;
        inst_t inst;
        next_delivery(pc, inst);
        compare_addr("stall_entry", from, pc);
        compare_inst("stall_entry", expected_inst(from), inst);
        stall_i <= 1'b1;
        for (int k = 0; k < 3; k++) begin
            next_delivery(pc, inst);
            compare_addr("stall", from + 64'd4, pc);
            compare_inst("stall", expected_inst(from + 64'd4), inst);
        end
        stall_i <= 1'b0;
        // the fetch already under way returns the held pc once more
        check_run("stall_release", from + 64'd4, 3);
    endtask

    initial begin
        rst_n_i    <= 1'b0;
        jal_i      <= 1'b0;
        branch_i   <= 1'b0;
        jalr_i     <= 1'b0;
        trap_i     <= 1'b0;
        stall_i    <= 1'b0;
        alu_res_i  <= '0;
        ex_pc_i    <= '0;
        imm_i      <= '0;
        rs1_data_i <= '0;
        mtvec_i    <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        check_run("sequential", RESET_PC, 6);
        check_run("random_delays", RESET_PC + 64'd24, 20);
        test_jal(RESET_PC + 64'd104, resume_pc);
        test_branch(resume_pc, resume_pc);
        test_jalr_trap(resume_pc, resume_pc);
        test_stall(resume_pc);
        $display("errors: pc %0d, instruction %0d", addr_errors, inst_errors);
        if (addr_errors + inst_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("errors: pc %0d, instruction %0d", addr_errors, inst_errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* test/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
    input logic               clk,
    input logic               rst_n_i,
    input logic               req_valid_i,
    input fetch_pkg::addr_t   req_addr_i,
    input logic               req_ready_i,
    input logic               resp_ready_i,
    input logic               inst_valid_i,
    input logic               jal_i,
    input logic               trap_i,
    input fetch_pkg::pc_src_e pc_src_i
);

    import fetch_pkg::*;

    // address phase holds until the handshake
    req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_addr_i)))
        else $error("request address or valid changed before ready");

    phase_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(req_valid_i && resp_ready_i))
        else $error("address and data phase active together");

    inst_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |=> !inst_valid_i)
        else $error("instruction valid held for two cycles");

    // jump must outrank a trap in the same cycle
    jal_over_trap: assert property (@(posedge clk) disable iff (!rst_n_i)
        (jal_i && trap_i) |-> (pc_src_i != TRAP))
        else $error("trap taken while jal was raised");

endmodule

bind fetch_top fetch_assertions u_assertions (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_o),
    .req_addr_i   (req_addr_o),
    .req_ready_i  (req_ready_i),
    .resp_ready_i (resp_ready_o),
    .inst_valid_i (inst_valid_o),
    .jal_i        (jal_i),
    .trap_i       (trap_i),
    .pc_src_i     (u_pc_gen.pc_src)
);

/* test/fetch_mem_model.sv */
`timescale 1ns/1ps

module fetch_mem_model (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             req_valid_i,
    input  fetch_pkg::addr_t req_addr_i,
    output logic             req_ready_o,
    output logic             resp_valid_o,
    output fetch_pkg::data_t resp_data_o,
    input  logic             resp_ready_i
);

    import fetch_pkg::*;

    logic [31:0] rng;
    logic [1:0]  ready_wait;
    logic [1:0]  valid_wait;
    logic        pending;
    addr_t       beat_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lower word is the aligned address xor 0x13, upper word adds 4
    function automatic data_t beat_word(input addr_t a);
        logic [31:0] lo;
        lo = a[31:0] ^ 32'h13;
        return {lo + 32'd4, lo};
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rng          <= 32'd3;
            ready_wait   <= 2'd0;
            valid_wait   <= 2'd0;
            pending      <= 1'b0;
            beat_addr    <= '0;
            req_ready_o  <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_data_o  <= '0;
        end else begin
            // address phase, delays for the next request are drawn here
            if (req_valid_i && req_ready_o) begin
                req_ready_o <= 1'b0;
                pending     <= 1'b1;
                beat_addr   <= {req_addr_i[ADDR_W-1:3], 3'b000};
                ready_wait  <= rng[1:0];
                valid_wait  <= rng[3:2];
                rng         <= xorshift(rng);
            end else if (req_valid_i) begin
                if (ready_wait == 2'd0) begin
                    req_ready_o <= 1'b1;
                end else begin
                    ready_wait <= ready_wait - 2'd1;
                end
            end
            // data phase
            if (resp_valid_o && resp_ready_i) begin
                resp_valid_o <= 1'b0;
                resp_data_o  <= '0;
                pending      <= 1'b0;
            end else if (pending && !resp_valid_o) begin
                if (valid_wait == 2'd0) begin
                    resp_valid_o <= 1'b1;
                    resp_data_o  <= beat_word(beat_addr);
                end else begin
                    valid_wait <= valid_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              rst_n_i,

    // redirect and control strobes
    input  logic              jal_i,
    input  logic              branch_i,
    input  fetch_pkg::addr_t  alu_res_i,
    input  logic              jalr_i,
    input  logic              trap_i,
    input  fetch_pkg::addr_t  ex_pc_i,
    input  fetch_pkg::addr_t  imm_i,
    input  fetch_pkg::addr_t  rs1_data_i,
    input  fetch_pkg::addr_t  mtvec_i,
    input  logic              stall_i,

    // instruction read bus
    output logic              req_valid_o,
    output fetch_pkg::addr_t  req_addr_o,
    input  logic              req_ready_i,
    input  logic              resp_valid_i,
    input  fetch_pkg::data_t  resp_data_i,
    output logic              resp_ready_o,

    // fetched instruction
    output logic              inst_valid_o,
    output fetch_pkg::inst_t  inst_o,
    output fetch_pkg::addr_t  pc_o
);

    import fetch_pkg::*;

    addr_t pc;
    logic  redirect;
    logic  accept;
    logic  beat_done;
    addr_t beat_addr;
    data_t beat_data;

    fetch_bus_ctrl u_bus_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .req_valid_o  (req_valid_o),
        .req_addr_o   (req_addr_o),
        .req_ready_i  (req_ready_i),
        .resp_valid_i (resp_valid_i),
        .resp_data_i  (resp_data_i),
        .resp_ready_o (resp_ready_o),
        .beat_done_o  (beat_done),
        .beat_addr_o  (beat_addr),
        .beat_data_o  (beat_data)
    );

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .jal_i      (jal_i),
        .branch_i   (branch_i),
        .alu_res_i  (alu_res_i),
        .jalr_i     (jalr_i),
        .trap_i     (trap_i),
        .ex_pc_i    (ex_pc_i),
        .imm_i      (imm_i),
        .rs1_data_i (rs1_data_i),
        .mtvec_i    (mtvec_i),
        .stall_i    (stall_i),
        .accept_i   (accept),
        .pc_o       (pc),
        .redirect_o (redirect)
    );

    fetch_output u_output (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .beat_done_i  (beat_done),
        .beat_addr_i  (beat_addr),
        .beat_data_i  (beat_data),
        .pc_i         (pc),
        .redirect_i   (redirect),
        .accept_o     (accept),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

endmodule

/* design/fetch_output.sv */
`timescale 1ns/1ps

module fetch_output (
    input  logic              clk,
    input  logic              rst_n_i,

    // beat from the bus controller
    input  logic              beat_done_i,
    input  fetch_pkg::addr_t  beat_addr_i,
    input  fetch_pkg::data_t  beat_data_i,

    // pc state
    input  fetch_pkg::addr_t  pc_i,
    input  logic              redirect_i,
    output logic              accept_o,

    // delivered instruction, one cycle pulse
    output logic              inst_valid_o,
    output fetch_pkg::inst_t  inst_o,
    output fetch_pkg::addr_t  pc_o
);

    import fetch_pkg::*;

    inst_t inst_sel;

    // a beat counts only if it was fetched for the current pc
    // and no redirect is moving the pc away right now
    assign accept_o = beat_done_i && (beat_addr_i == pc_i) && !redirect_i;

    // pick the 32-bit word inside the 8-byte beat
    assign inst_sel = beat_addr_i[HALF_SEL_BIT] ? beat_data_i[DATA_W-1:INST_W]
                                                : beat_data_i[INST_W-1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
            pc_o         <= '0;
        end else begin
            inst_valid_o <= accept_o;
            // outputs read zero between deliveries
            inst_o       <= accept_o ? inst_sel : '0;
            pc_o         <= accept_o ? beat_addr_i : '0;
        end
    end

endmodule

/* design/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              rst_n_i,

    // redirect strobes from later stages
    input  logic              jal_i,
    input  logic              branch_i,
    input  fetch_pkg::addr_t  alu_res_i,
    input  logic              jalr_i,
    input  logic              trap_i,
    input  fetch_pkg::addr_t  ex_pc_i,
    input  fetch_pkg::addr_t  imm_i,
    input  fetch_pkg::addr_t  rs1_data_i,
    input  fetch_pkg::addr_t  mtvec_i,
    input  logic              stall_i,

    // current pc was delivered this cycle
    input  logic              accept_i,

    output fetch_pkg::addr_t  pc_o,
    output logic              redirect_o
);

    import fetch_pkg::*;

    addr_t   pc;
    addr_t   pc_nxt;
    pc_src_e pc_src;

    addr_t   jump_target;
    addr_t   jalr_sum;
    logic    branch_taken;

    assign jump_target  = ex_pc_i + imm_i;
    assign jalr_sum     = rs1_data_i + imm_i;

    // branch resolves as taken when the compare result is zero
    assign branch_taken = branch_i && (alu_res_i == '0);

    // source priority: jump, jalr, trap, then advance
    always_comb begin
        if (jal_i || branch_taken) begin
            pc_src = JUMP;
        end else if (jalr_i) begin
            pc_src = JALR;
        end else if (trap_i) begin
            pc_src = TRAP;
        end else if (accept_i && !stall_i) begin
            pc_src = SEQ;
        end else begin
            pc_src = HOLD;
        end
    end

    always_comb begin
        case (pc_src)
            JUMP:    pc_nxt = jump_target;
            // jalr target has bit 0 forced low
            JALR:    pc_nxt = {jalr_sum[ADDR_W-1:1], 1'b0};
            TRAP:    pc_nxt = mtvec_i;
            SEQ:     pc_nxt = pc + addr_t'(INST_BYTES);
            default: pc_nxt = pc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_nxt;
        end
    end

    assign pc_o       = pc;
    // any jump, jalr or trap source, taken straight from the strobes
    assign redirect_o = jal_i || branch_taken || jalr_i || trap_i;

endmodule

/* design/fetch_bus_ctrl.sv */
`timescale 1ns/1ps

module fetch_bus_ctrl (
    input  logic              clk,
    input  logic              rst_n_i,

    // current fetch address
    input  fetch_pkg::addr_t  pc_i,

    // read bus, address phase
    output logic              req_valid_o,
    output fetch_pkg::addr_t  req_addr_o,
    input  logic              req_ready_i,

    // read bus, data phase
    input  logic              resp_valid_i,
    input  fetch_pkg::data_t  resp_data_i,
    output logic              resp_ready_o,

    // completed beat towards the output stage
    output logic              beat_done_o,
    output fetch_pkg::addr_t  beat_addr_o,
    output fetch_pkg::data_t  beat_data_o
);

    import fetch_pkg::*;

    bus_state_e state;
    bus_state_e state_nxt;

    // address of the outstanding read
    addr_t      req_addr_q;

    // one read in flight at a time
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                state_nxt = ADDR;
            end
            ADDR: begin
                // wait out back-pressure from the memory
                if (req_ready_i) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (resp_valid_i) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // pc is sampled only when leaving idle, so the address stays put
    // even if the pc moves while the bus stalls
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr_q <= pc_i;
        end
    end

    assign req_valid_o  = (state == ADDR);
    assign req_addr_o   = req_addr_q;
    assign resp_ready_o = (state == DATA);

    // high in the data handshake cycle itself
    assign beat_done_o  = (state == DATA) && resp_valid_i;
    assign beat_addr_o  = req_addr_q;
    assign beat_data_o  = resp_data_i;

endmodule

/* design/fetch_pkg.sv */
package fetch_pkg;

    // bus and instruction widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int INST_W = 32;

    // bytes per instruction, used for the sequential advance
    localparam int INST_BYTES = INST_W / 8;

    // byte address bit that picks the upper half of a beat
    localparam int HALF_SEL_BIT = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [INST_W-1:0] inst_t;

    // read bus controller states
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } bus_state_e;

    // where the next pc comes from
    typedef enum logic [2:0] {
        SEQ,
        JUMP,
        JALR,
        TRAP,
        HOLD
    } pc_src_e;

endpackage
